//--- isa_pkg.sv
package isa_pkg;

    // Register view with the four opcode fields of the 3R and 2RI5 formats
    typedef struct packed {
        logic [5:0] op_31_26;
        logic [3:0] op_25_22;
        logic [1:0] op_21_20;
        logic [4:0] op_19_15;
        logic [4:0] rk;
        logic [4:0] rj;
        logic [4:0] rd;
    } reg_view_t;

    // Immediate view; si12 sits in the low twelve bits of i16
    typedef struct packed {
        logic [5:0]  op;
        logic [15:0] i16;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } imm_view_t;

    typedef union packed {
        reg_view_t r;
        imm_view_t i;
    } inst_word_t;

    localparam logic [5:0] OP6_ALU     = 6'h00;
    localparam logic [5:0] OP6_LU12I_W = 6'h05;
    localparam logic [5:0] OP6_MEM     = 6'h0a;
    localparam logic [5:0] OP6_JIRL    = 6'h13;
    localparam logic [5:0] OP6_B       = 6'h14;
    localparam logic [5:0] OP6_BL      = 6'h15;
    localparam logic [5:0] OP6_BEQ     = 6'h16;
    localparam logic [5:0] OP6_BNE     = 6'h17;

    localparam logic [3:0] OP4_3R      = 4'h0;
    localparam logic [3:0] OP4_SHIFT   = 4'h1;
    localparam logic [3:0] OP4_LD_W    = 4'h2;
    localparam logic [3:0] OP4_ST_W    = 4'h6;
    localparam logic [3:0] OP4_ADDI_W  = 4'ha;

    localparam logic [1:0] OP2_SHIFT   = 2'h0;
    localparam logic [1:0] OP2_3R      = 2'h1;

    localparam logic [4:0] OP5_ADD_W   = 5'h00;
    localparam logic [4:0] OP5_SLLI_W  = 5'h01;
    localparam logic [4:0] OP5_SUB_W   = 5'h02;
    localparam logic [4:0] OP5_SLT     = 5'h04;
    localparam logic [4:0] OP5_SLTU    = 5'h05;
    localparam logic [4:0] OP5_NOR     = 5'h08;
    localparam logic [4:0] OP5_AND     = 5'h09;
    localparam logic [4:0] OP5_SRLI_W  = 5'h09;
    localparam logic [4:0] OP5_OR      = 5'h0a;
    localparam logic [4:0] OP5_XOR     = 5'h0b;
    localparam logic [4:0] OP5_SRAI_W  = 5'h11;

    typedef enum logic [2:0] {
        IMM_UI5,
        IMM_SI12,
        IMM_SI16,
        IMM_SI20,
        IMM_SI26,
        IMM_FOUR
    } imm_kind_t;

endpackage

//--- ctrl_pkg.sv
package ctrl_pkg;

    typedef enum logic [2:0] {
        IF  = 3'd0,
        ID  = 3'd1,
        EXE = 3'd2,
        MEM = 3'd3,
        WB  = 3'd4
    } cpu_state_t;

    // One bit per ALU operation, at most one bit set
    typedef logic [11:0] alu_op_t;

    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

endpackage

//--- inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    input  isa_pkg::inst_word_t inst,
    output ctrl_pkg::alu_op_t   alu_op,
    output logic                src1_is_pc,
    output logic                src2_is_imm,
    output logic                src_reg_is_rd,
    output logic                res_from_mem,
    output logic                gr_we,
    output logic                mem_we,
    output logic                is_branch,
    output logic                is_cond_branch,
    output logic                is_ld,
    output logic                is_st,
    output logic                is_jirl,
    output logic [4:0]          dest,
    output logic [4:0]          raddr1,
    output logic [4:0]          raddr2,
    output logic [31:0]         imm,
    output logic [31:0]         br_offs
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    logic        grp_3r;
    logic        grp_shift;
    logic        inst_add_w, inst_sub_w, inst_slt, inst_sltu;
    logic        inst_nor, inst_and, inst_or, inst_xor;
    logic        inst_slli_w, inst_srli_w, inst_srai_w, inst_addi_w;
    logic        inst_b, inst_bl, inst_beq, inst_bne, inst_lu12i_w;
    logic [11:0] si12;
    logic [15:0] si16;
    logic [19:0] si20;
    logic [25:0] si26;
    imm_kind_t   imm_kind;

    // The op prefix sits in the same bits of both views
    assign grp_3r    = inst.r.op_31_26 == OP6_ALU && inst.r.op_25_22 == OP4_3R
                       && inst.r.op_21_20 == OP2_3R;
    assign grp_shift = inst.r.op_31_26 == OP6_ALU && inst.r.op_25_22 == OP4_SHIFT
                       && inst.r.op_21_20 == OP2_SHIFT;

    assign inst_add_w   = grp_3r && inst.r.op_19_15 == OP5_ADD_W;
    assign inst_sub_w   = grp_3r && inst.r.op_19_15 == OP5_SUB_W;
    assign inst_slt     = grp_3r && inst.r.op_19_15 == OP5_SLT;
    assign inst_sltu    = grp_3r && inst.r.op_19_15 == OP5_SLTU;
    assign inst_nor     = grp_3r && inst.r.op_19_15 == OP5_NOR;
    assign inst_and     = grp_3r && inst.r.op_19_15 == OP5_AND;
    assign inst_or      = grp_3r && inst.r.op_19_15 == OP5_OR;
    assign inst_xor     = grp_3r && inst.r.op_19_15 == OP5_XOR;
    assign inst_slli_w  = grp_shift && inst.r.op_19_15 == OP5_SLLI_W;
    assign inst_srli_w  = grp_shift && inst.r.op_19_15 == OP5_SRLI_W;
    assign inst_srai_w  = grp_shift && inst.r.op_19_15 == OP5_SRAI_W;
    assign inst_addi_w  = inst.i.op == OP6_ALU && inst.r.op_25_22 == OP4_ADDI_W;
    assign is_ld        = inst.i.op == OP6_MEM && inst.r.op_25_22 == OP4_LD_W;
    assign is_st        = inst.i.op == OP6_MEM && inst.r.op_25_22 == OP4_ST_W;
    assign is_jirl      = inst.i.op == OP6_JIRL;
    assign inst_b       = inst.i.op == OP6_B;
    assign inst_bl      = inst.i.op == OP6_BL;
    assign inst_beq     = inst.i.op == OP6_BEQ;
    assign inst_bne     = inst.i.op == OP6_BNE;
    assign inst_lu12i_w = inst.i.op == OP6_LU12I_W && !inst.i.i16[15];

    always_comb begin
        alu_op           = '0;
        alu_op[ALU_ADD]  = inst_add_w | inst_addi_w | is_ld | is_st | is_jirl | inst_bl;
        alu_op[ALU_SUB]  = inst_sub_w;
        alu_op[ALU_SLT]  = inst_slt;
        alu_op[ALU_SLTU] = inst_sltu;
        alu_op[ALU_AND]  = inst_and;
        alu_op[ALU_NOR]  = inst_nor;
        alu_op[ALU_OR]   = inst_or;
        alu_op[ALU_XOR]  = inst_xor;
        alu_op[ALU_SLL]  = inst_slli_w;
        alu_op[ALU_SRL]  = inst_srli_w;
        alu_op[ALU_SRA]  = inst_srai_w;
        alu_op[ALU_LUI]  = inst_lu12i_w;
    end

    assign is_branch      = inst_b | inst_bl | inst_beq | inst_bne;
    assign is_cond_branch = inst_beq | inst_bne;
    assign src1_is_pc     = is_jirl | inst_bl;
    assign src2_is_imm    = inst_slli_w | inst_srli_w | inst_srai_w | inst_addi_w
                            | is_ld | is_st | inst_lu12i_w | is_jirl | inst_bl;
    assign src_reg_is_rd  = inst_beq | inst_bne | is_st;
    assign res_from_mem   = is_ld;
    assign mem_we         = is_st;
    // Unknown encodings fall out here with no register write
    assign gr_we          = grp_3r & (|alu_op) | inst_slli_w | inst_srli_w | inst_srai_w
                            | inst_addi_w | inst_lu12i_w | is_ld | is_jirl | inst_bl;

    assign dest   = inst_bl ? 5'd1 : inst.r.rd;
    assign raddr1 = inst.r.rj;
    assign raddr2 = src_reg_is_rd ? inst.r.rd : inst.r.rk;

    assign si12 = inst.i.i16[11:0];
    assign si16 = inst.i.i16;
    assign si20 = {inst.i.i16[14:0], inst.i.rj};
    assign si26 = {inst.i.rj, inst.i.rd, inst.i.i16};

    always_comb begin
        if (src1_is_pc) begin
            imm_kind = IMM_FOUR;
        end else if (grp_shift) begin
            imm_kind = IMM_UI5;
        end else if (inst_lu12i_w) begin
            imm_kind = IMM_SI20;
        end else if (inst_b) begin
            imm_kind = IMM_SI26;
        end else if (is_cond_branch) begin
            imm_kind = IMM_SI16;
        end else begin
            imm_kind = IMM_SI12;
        end
    end

    always_comb begin
        case (imm_kind)
            IMM_UI5:  imm = {27'b0, inst.r.rk};
            IMM_SI16: imm = {{16{si16[15]}}, si16};
            IMM_SI20: imm = {si20, 12'b0};
            IMM_SI26: imm = {{6{si26[25]}}, si26};
            IMM_FOUR: imm = 32'd4;
            default:  imm = {{20{si12[11]}}, si12};
        endcase
    end

    // b and bl carry a 26-bit word offset, jirl and the conditional branches a 16-bit one
    assign br_offs = (inst_b | inst_bl) ? {{4{si26[25]}}, si26, 2'b0}
                                        : {{14{si16[15]}}, si16, 2'b0};

endmodule

//--- regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic        clk,
    input  logic [4:0]  raddr1,
    output logic [31:0] rdata1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata2,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);

    logic [31:0] rf [31:0];

    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin
            rf[waddr] <= wdata;
        end
    end

    // r0 is never written, so its entry is masked on the way out
    assign rdata1 = (raddr1 == 5'd0) ? 32'b0 : rf[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'b0 : rf[raddr2];

endmodule

//--- alu.sv
`timescale 1ns/1ps

module alu (
    input  ctrl_pkg::alu_op_t alu_op,
    input  logic [31:0]       alu_src1,
    input  logic [31:0]       alu_src2,
    output logic [31:0]       alu_result
);
    import ctrl_pkg::*;

    logic [4:0]  shamt;
    logic [31:0] add_res;
    logic [31:0] sub_res;
    logic        slt_res;
    logic        sltu_res;
    logic [31:0] sll_res;
    logic [31:0] srl_res;
    logic [31:0] sra_res;

    assign shamt    = alu_src2[4:0];
    assign add_res  = alu_src1 + alu_src2;
    assign sub_res  = alu_src1 - alu_src2;
    assign slt_res  = $signed(alu_src1) < $signed(alu_src2);
    assign sltu_res = alu_src1 < alu_src2;
    assign sll_res  = alu_src1 << shamt;
    assign srl_res  = alu_src1 >> shamt;
    assign sra_res  = 32'($signed(alu_src1) >>> shamt);

    // The op vector is one-hot, so the masked results can simply be ORed
    assign alu_result = ({32{alu_op[ALU_ADD]}}  & add_res)
                      | ({32{alu_op[ALU_SUB]}}  & sub_res)
                      | ({32{alu_op[ALU_SLT]}}  & {31'b0, slt_res})
                      | ({32{alu_op[ALU_SLTU]}} & {31'b0, sltu_res})
                      | ({32{alu_op[ALU_AND]}}  & (alu_src1 & alu_src2))
                      | ({32{alu_op[ALU_NOR]}}  & ~(alu_src1 | alu_src2))
                      | ({32{alu_op[ALU_OR]}}   & (alu_src1 | alu_src2))
                      | ({32{alu_op[ALU_XOR]}}  & (alu_src1 ^ alu_src2))
                      | ({32{alu_op[ALU_SLL]}}  & sll_res)
                      | ({32{alu_op[ALU_SRL]}}  & srl_res)
                      | ({32{alu_op[ALU_SRA]}}  & sra_res)
                      | ({32{alu_op[ALU_LUI]}}  & alu_src2);

endmodule

//--- mycpu_top.sv
`timescale 1ns/1ps

module mycpu_top #(
    parameter logic [31:0] reset_pc = 32'h1c00_0000
) (
    input  logic        clk,
    input  logic        reset,
    output logic        inst_sram_we,
    output logic [31:0] inst_sram_addr,
    output logic [31:0] inst_sram_wdata,
    input  logic [31:0] inst_sram_rdata,
    output logic        data_sram_we,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    input  logic [31:0] data_sram_rdata,
    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_we,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    cpu_state_t  state, next_state;
    inst_word_t  ir;
    logic [31:0] pc, npc_q, id_next_pc, br_target;
    logic [31:0] rj_q, rkd_q, result_q;
    alu_op_t     alu_op;
    logic        src1_is_pc, src2_is_imm, src_reg_is_rd, res_from_mem;
    logic        gr_we, mem_we, is_branch, is_cond_branch, is_ld, is_st, is_jirl;
    logic [4:0]  dest, raddr1, raddr2;
    logic [31:0] imm, br_offs, rf_rdata1, rf_rdata2;
    logic [31:0] alu_src1, alu_src2, alu_result;
    logic        br_on_ne, br_taken, rf_we;

    inst_decoder u_inst_decoder (
        .inst(ir), .alu_op(alu_op), .src1_is_pc(src1_is_pc), .src2_is_imm(src2_is_imm),
        .src_reg_is_rd(src_reg_is_rd), .res_from_mem(res_from_mem), .gr_we(gr_we),
        .mem_we(mem_we), .is_branch(is_branch), .is_cond_branch(is_cond_branch),
        .is_ld(is_ld), .is_st(is_st), .is_jirl(is_jirl), .dest(dest), .raddr1(raddr1),
        .raddr2(raddr2), .imm(imm), .br_offs(br_offs)
    );

    regfile u_regfile (
        .clk(clk), .raddr1(raddr1), .rdata1(rf_rdata1), .raddr2(raddr2),
        .rdata2(rf_rdata2), .we(rf_we), .waddr(dest), .wdata(result_q)
    );

    alu u_alu (
        .alu_op(alu_op), .alu_src1(alu_src1), .alu_src2(alu_src2), .alu_result(alu_result)
    );

    always_comb begin
        case (state)
            IF:      next_state = ID;
            // b, beq and bne finish in ID
            ID:      next_state = (is_branch && !gr_we) ? IF : EXE;
            EXE:     next_state = (is_ld || is_st) ? MEM : WB;
            MEM:     next_state = is_ld ? WB : IF;
            default: next_state = IF;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IF;
            pc    <= reset_pc;
        end else begin
            state <= next_state;
            if (state != IF && next_state == IF) begin
                pc <= (state == ID) ? id_next_pc : npc_q;
            end
        end
    end

    // Branches resolve in ID straight from the register file outputs
    assign br_on_ne   = ir.i.op == OP6_BNE;
    assign br_taken   = (is_cond_branch && ((rf_rdata1 == rf_rdata2) != br_on_ne))
                        || (is_branch && !is_cond_branch) || is_jirl;
    assign br_target  = is_jirl ? rf_rdata1 + br_offs : pc + br_offs;
    assign id_next_pc = br_taken ? br_target : pc + 32'd4;

    always_ff @(posedge clk) begin
        case (state)
            IF: ir <= inst_sram_rdata;
            ID: begin
                rj_q  <= rf_rdata1;
                npc_q <= id_next_pc;
                if (src_reg_is_rd || !src2_is_imm) begin
                    rkd_q <= rf_rdata2;
                end
            end
            EXE: result_q <= alu_result;
            MEM: begin
                if (res_from_mem) begin
                    result_q <= data_sram_rdata;
                end
            end
            default: ;
        endcase
    end

    assign alu_src1 = src1_is_pc ? pc : rj_q;
    assign alu_src2 = src2_is_imm ? imm : rkd_q;

    assign inst_sram_we    = 1'b0;
    assign inst_sram_addr  = pc;
    assign inst_sram_wdata = 32'b0;

    assign data_sram_we    = (state == MEM) && mem_we;
    assign data_sram_addr  = result_q;
    assign data_sram_wdata = rkd_q;

    assign rf_we = (state == WB) && gr_we && (dest != 5'd0);

    // pc still holds this instruction's address throughout WB
    assign debug_wb_pc       = pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = dest;
    assign debug_wb_rf_wdata = result_q;

endmodule

//--- mycpu_assert.sv
`timescale 1ns/1ps

module mycpu_assert (
    input logic                 clk,
    input logic                 reset,
    input ctrl_pkg::cpu_state_t state,
    input logic                 data_sram_we,
    input logic [3:0]           debug_wb_rf_we
);
    import ctrl_pkg::*;

    // Cycles spent since the core last left IF
    logic [2:0] busy_cycles;

    always_ff @(posedge clk) begin
        if (reset || state == IF) begin
            busy_cycles <= 3'd0;
        end else begin
            busy_cycles <= busy_cycles + 3'd1;
        end
    end

    assert property (@(posedge clk) disable iff (reset) data_sram_we |-> state == MEM)
        else $error("data_sram_we is high outside MEM");

    assert property (@(posedge clk) disable iff (reset) (debug_wb_rf_we != 4'h0) |-> state == WB)
        else $error("debug_wb_rf_we is high outside WB");

    // The longest instruction leaves IF for four states
    assert property (@(posedge clk) disable iff (reset) busy_cycles <= 3'd4)
        else $error("state machine did not return to IF within five cycles");

endmodule

bind mycpu_top mycpu_assert u_mycpu_assert (
    .clk(clk), .reset(reset), .state(state),
    .data_sram_we(data_sram_we), .debug_wb_rf_we(debug_wb_rf_we)
);

//--- tb_mycpu.sv
`timescale 1ns/1ps

module tb_mycpu;
    import isa_pkg::*;

    localparam logic [31:0] IBASE = 32'h1c00_0000;
    localparam logic [31:0] DBASE = 32'h0000_0000;
    localparam logic [9:0] OP10_ADDI = {OP6_ALU, OP4_ADDI_W};
    localparam logic [9:0] OP10_LD = {OP6_MEM, OP4_LD_W};
    localparam logic [9:0] OP10_ST = {OP6_MEM, OP4_ST_W};

    logic clk, reset;
    logic inst_sram_we, data_sram_we;
    logic [31:0] inst_sram_addr, inst_sram_wdata, inst_sram_rdata;
    logic [31:0] data_sram_addr, data_sram_wdata, data_sram_rdata;
    logic [31:0] debug_wb_pc, debug_wb_rf_wdata;
    logic [3:0] debug_wb_rf_we;
    logic [4:0] debug_wb_rf_wnum;
    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [15:0] lfsr;
    int prog_len, test_errs, passed, failed, exp_stores;
    logic [4:0] exp_num [$];
    logic [31:0] exp_pc [$];
    logic [31:0] exp_val [$];

    mycpu_top #(.reset_pc(IBASE)) mycpu_top_i (
        .clk(clk), .reset(reset), .inst_sram_we(inst_sram_we),
        .inst_sram_addr(inst_sram_addr), .inst_sram_wdata(inst_sram_wdata),
        .inst_sram_rdata(inst_sram_rdata), .data_sram_we(data_sram_we),
        .data_sram_addr(data_sram_addr), .data_sram_wdata(data_sram_wdata),
        .data_sram_rdata(data_sram_rdata), .debug_wb_pc(debug_wb_pc),
        .debug_wb_rf_we(debug_wb_rf_we), .debug_wb_rf_wnum(debug_wb_rf_wnum),
        .debug_wb_rf_wdata(debug_wb_rf_wdata)
    );

    assign inst_sram_rdata = imem[8'((inst_sram_addr - IBASE) >> 2)];
    assign data_sram_rdata = dmem[8'((data_sram_addr - DBASE) >> 2)];

    always @(posedge clk) begin
        if (data_sram_we) begin
            dmem[8'((data_sram_addr - DBASE) >> 2)] <= data_sram_wdata;
        end
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic fb;
        v = 32'h0;
        for (int k = 0; k < n; k++) begin
            fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [31:0] enc_3r(input logic [4:0] op5, rd, rj, rk);
        return {OP6_ALU, OP4_3R, OP2_3R, op5, rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_shift(input logic [4:0] op5, rd, rj, ui5);
        return {OP6_ALU, OP4_SHIFT, OP2_SHIFT, op5, ui5, rj, rd};
    endfunction

    function automatic logic [31:0] enc_2ri12(input logic [9:0] op10, input logic [4:0] rd, rj,
                                               input logic [11:0] si12);
        return {op10, si12, rj, rd};
    endfunction

    function automatic logic [31:0] enc_2ri16(input logic [5:0] op6, input logic [4:0] rd, rj,
                                               input logic [15:0] offs);
        return {op6, offs, rj, rd};
    endfunction

    function automatic logic [31:0] enc_b(input logic [5:0] op6, input logic [25:0] offs);
        return {op6, offs[15:0], offs[25:16]};
    endfunction

    // Reference ALU: 0 add, 1 sub, 2 slt, 3 sltu, 4 and, 5 nor, 6 or, 7 xor, 8 sll, 9 srl, 10 sra
    function automatic logic [31:0] ref_alu(input int op, input logic [31:0] a, b);
        case (op)
            0: return a + b;
            1: return a - b;
            2: return {31'b0, $signed(a) < $signed(b)};
            3: return {31'b0, a < b};
            4: return a & b;
            5: return ~(a | b);
            6: return a | b;
            7: return a ^ b;
            8: return a << b[4:0];
            9: return a >> b[4:0];
            default: return 32'($signed(a) >>> b[4:0]);
        endcase
    endfunction

    function automatic logic [31:0] pc_now();
        return IBASE + 32'(4 * prog_len);
    endfunction

    task automatic emit(input logic [31:0] word, input logic [4:0] rd = 0,
                        input logic [31:0] val = 0, input bit writes = 0);
        if (writes) begin
            exp_num.push_back(rd);
            exp_pc.push_back(pc_now());
            exp_val.push_back(val);
        end
        imem[8'(prog_len)] = word;
        prog_len++;
    endtask

    task automatic load_const(input logic [4:0] rd, output logic [31:0] val);
        logic [19:0] hi;
        logic [11:0] lo;
        hi = 20'(rand_bits(20));
        lo = 12'(rand_bits(12));
        emit({OP6_LU12I_W, 1'b0, hi, rd}, rd, {hi, 12'h0}, 1);
        val = ref_alu(0, {hi, 12'h0}, {{20{lo[11]}}, lo});
        emit(enc_2ri12(OP10_ADDI, rd, rd, lo), rd, val, 1);
    endtask

    task automatic check_val(input string sig, input logic [31:0] got, exp);
        if (got !== exp) begin
            $display("Error %s got %h expected %h", sig, got, exp);
            test_errs++;
        end
    endtask

    task automatic begin_test();
        logic [31:0] addr;
        test_errs = 0;
        prog_len = 0;
        exp_stores = 0;
        exp_num.delete();
        exp_pc.delete();
        exp_val.delete();
        for (int i = 0; i < 256; i++) begin
            addr = IBASE + 32'(4 * i);
            // Unused opcode 0x3f, so a stray fetch retires as a no-op
            imem[8'(i)] = {6'h3f, 26'(addr) ^ 26'(addr >> 26)};
            dmem[8'(i)] = 32'hd00d_0000 ^ (DBASE + 32'(4 * i));
        end
    endtask

    task automatic pulse_reset();
        @(negedge clk);
        reset = 1'b1;
        repeat (16) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic run_program();
        int got;
        int cyc;
        int tail;
        int stores;
        got = 0;
        cyc = 0;
        tail = 0;
        stores = 0;
        pulse_reset();
        while (cyc < 800 && tail < 30) begin
            @(negedge clk);
            cyc++;
            if (got >= exp_num.size()) tail++;
            check_val("inst_sram_we", 32'(inst_sram_we), 32'h0);
            if ($isunknown(inst_sram_wdata)) begin
                $display("inst_sram_wdata is not driven to a known value");
                test_errs++;
            end
            if (data_sram_we) begin
                stores++;
            end
            if (debug_wb_rf_we != 4'h0) begin
                if (got >= exp_num.size()) begin
                    $display("Unexpected write to r%0d at pc %h", debug_wb_rf_wnum, debug_wb_pc);
                    test_errs++;
                end else begin
                    check_val("debug_wb_rf_we", 32'(debug_wb_rf_we), 32'hf);
                    check_val("debug_wb_rf_wnum", 32'(debug_wb_rf_wnum), 32'(exp_num[got]));
                    check_val("debug_wb_pc", debug_wb_pc, exp_pc[got]);
                    check_val("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_val[got]);
                end
                got++;
            end
        end
        if (got < exp_num.size()) begin
            $display("Timed out after %0d of %0d register writes", got, exp_num.size());
            test_errs++;
        end
        if (stores != exp_stores) begin
            $display("Saw %0d data store cycles but expected %0d", stores, exp_stores);
            test_errs++;
        end
    endtask

    task automatic end_test(input string name);
        if (test_errs == 0) begin
            passed++;
            $display("%s: passed", name);
        end else begin
            failed++;
            $display("%s: failed with %0d errors", name, test_errs);
        end
    endtask

    task automatic reset_test();
        begin_test();
        emit(enc_b(OP6_B, 26'd0));
        pulse_reset();
        check_val("inst_sram_addr", inst_sram_addr, IBASE);
        check_val("debug_wb_rf_we", 32'(debug_wb_rf_we), 32'h0);
        check_val("data_sram_we", 32'(data_sram_we), 32'h0);
        end_test("reset");
    endtask

    task automatic alu_ops_test();
        logic [31:0] a, b;
        logic [4:0] op5s [8] = '{OP5_ADD_W, OP5_SUB_W, OP5_SLT, OP5_SLTU,
                                 OP5_NOR, OP5_AND, OP5_OR, OP5_XOR};
        int codes [8] = '{0, 1, 2, 3, 5, 4, 6, 7};
        begin_test();
        load_const(5'd4, a);
        load_const(5'd5, b);
        for (int k = 0; k < 8; k++) begin
            emit(enc_3r(op5s[k], 5'(6 + k), 5'd4, 5'd5), 5'(6 + k), ref_alu(codes[k], a, b), 1);
        end
        emit(enc_b(OP6_B, 26'd0));
        run_program();
        end_test("three-register ops");
    endtask

    task automatic imm_ops_test();
        logic [31:0] a;
        logic [4:0] amt;
        logic [11:0] neg;
        logic [4:0] shift_ops [3] = '{OP5_SLLI_W, OP5_SRLI_W, OP5_SRAI_W};
        begin_test();
        load_const(5'd4, a);
        for (int k = 0; k < 3; k++) begin
            amt = 5'(rand_bits(5));
            emit(enc_shift(shift_ops[k], 5'(6 + k), 5'd4, amt), 5'(6 + k),
                 ref_alu(8 + k, a, {27'b0, amt}), 1);
        end
        neg = 12'h000 - (12'(rand_bits(10)) + 12'd1);
        emit(enc_2ri12(OP10_ADDI, 5'd9, 5'd4, neg), 5'd9, ref_alu(0, a, {{20{neg[11]}}, neg}), 1);
        emit(enc_2ri12(OP10_ADDI, 5'd0, 5'd4, neg));
        emit(enc_3r(OP5_ADD_W, 5'd10, 5'd0, 5'd4), 5'd10, a, 1);
        emit(enc_b(OP6_B, 26'd0));
        run_program();
        end_test("shifts and immediates");
    endtask

    task automatic mem_test();
        logic [31:0] v;
        begin_test();
        exp_stores = 1;
        emit(enc_2ri12(OP10_ADDI, 5'd4, 5'd0, 12'h100), 5'd4, 32'h100, 1);
        load_const(5'd5, v);
        emit(enc_2ri12(OP10_ST, 5'd5, 5'd4, 12'h008));
        emit(enc_2ri12(OP10_LD, 5'd6, 5'd4, 12'h008), 5'd6, v, 1);
        emit(enc_b(OP6_B, 26'd0));
        run_program();
        check_val("dmem[0x108]", dmem[8'((32'h108 - DBASE) >> 2)], v);
        end_test("store and load");
    endtask

    task automatic branch_test();
        begin_test();
        emit(enc_2ri12(OP10_ADDI, 5'd4, 5'd0, 12'd7), 5'd4, 32'd7, 1);
        emit(enc_2ri12(OP10_ADDI, 5'd5, 5'd0, 12'd7), 5'd5, 32'd7, 1);
        emit(enc_2ri12(OP10_ADDI, 5'd6, 5'd0, 12'd9), 5'd6, 32'd9, 1);
        emit(enc_2ri16(OP6_BEQ, 5'd5, 5'd4, 16'd2));
        emit(enc_2ri12(OP10_ADDI, 5'd7, 5'd0, 12'd1));
        emit(enc_2ri16(OP6_BEQ, 5'd6, 5'd4, 16'd2));
        emit(enc_2ri12(OP10_ADDI, 5'd8, 5'd0, 12'd2), 5'd8, 32'd2, 1);
        emit(enc_2ri16(OP6_BNE, 5'd6, 5'd4, 16'd2));
        emit(enc_2ri12(OP10_ADDI, 5'd9, 5'd0, 12'd3));
        emit(enc_2ri16(OP6_BNE, 5'd5, 5'd4, 16'd2));
        emit(enc_2ri12(OP10_ADDI, 5'd10, 5'd0, 12'd4), 5'd10, 32'd4, 1);
        emit(enc_b(OP6_B, 26'd2));
        emit(enc_2ri12(OP10_ADDI, 5'd11, 5'd0, 12'd5));
        emit(enc_2ri12(OP10_ADDI, 5'd12, 5'd0, 12'd6), 5'd12, 32'd6, 1);
        emit(enc_b(OP6_B, 26'd0));
        run_program();
        end_test("branches");
    endtask

    task automatic link_test();
        logic [31:0] p2, p4;
        begin_test();
        p2 = IBASE + 32'd8;
        p4 = IBASE + 32'd16;
        emit(enc_2ri12(OP10_ADDI, 5'd4, 5'd0, 12'd1), 5'd4, 32'd1, 1);
        emit(enc_b(OP6_BL, 26'd3), 5'd1, p2, 1);
        emit(enc_2ri12(OP10_ADDI, 5'd5, 5'd0, 12'd2));
        emit(enc_b(OP6_B, 26'd0));
        emit(enc_2ri12(OP10_ADDI, 5'd6, 5'd0, 12'd3), 5'd6, 32'd3, 1);
        emit(enc_2ri16(OP6_JIRL, 5'd7, 5'd1, 16'd0), 5'd7, p4 + 32'd8, 1);
        // The return lands on the instruction after bl
        exp_num.push_back(5'd5);
        exp_pc.push_back(p2);
        exp_val.push_back(32'd2);
        run_program();
        end_test("bl and jirl");
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #5ms;
        $display("Simulation timed out");
        $display("Something failed");
        $finish;
    end

    initial begin
        reset = 1'b1;
        lfsr = 16'd53;
        passed = 0;
        failed = 0;
        reset_test();
        alu_ops_test();
        imm_ops_test();
        mem_test();
        branch_test();
        link_test();
        $display("Tests: %0d passed, %0d failed", passed, failed);
        if (failed == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- sources.f
isa_pkg.sv
ctrl_pkg.sv
inst_decoder.sv
regfile.sv
alu.sv
mycpu_top.sv
mycpu_assert.sv
tb_mycpu.sv

//--- Makefile
VERILATOR = verilator
FLAGS = --binary --timing --assert -j 0
TOP = tb_mycpu
FILELIST = sources.f
PASS_MSG = Everything OK

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
